// File: hw/csumPkg.sv
`default_nettype none

package csumPkg;

	// ones' complement word, internet header style
	localparam int wordWidth = 16;

	// one word of checksum arithmetic
	// carries operands, the accumulator, the sum and the checksum field
	typedef logic [wordWidth-1:0] csumWord;

	// carry network inside the modulo adder
	// 0 serial, 1 brent-kung, 2 sklansky
	localparam int prefixSpeed = 1;

	// negative zero
	// a header with a correct checksum field sums to this
	localparam csumWord allOnes = '1;

endpackage

`default_nettype wire

// File: hw/cmdPkg.sv
`default_nettype none

package cmdPkg;

	// host command set, one per handshake
	typedef enum logic [1:0] {
		opClear   = 2'd0,  // acc back to zero
		opAdd     = 2'd1,  // acc += data
		opAddSwap = 2'd2,  // acc += data with bytes swapped, odd-aligned data
		opRead    = 2'd3   // no change, just present the results
	} cmdOp;

	// decode FSM for the four-phase req/ack handshake
	typedef enum logic [1:0] {
		idle     = 2'd0,  // waiting for req
		issue    = 2'd1,  // command captured, pulse goes out next
		waitDone = 2'd2,  // execute busy
		ackHigh  = 2'd3   // results valid, waiting for req to drop
	} hsState;

	// only one command in flight
	// the host may not raise req before it has seen ack low again
	// so no queueing is needed anywhere

endpackage

`default_nettype wire

// File: hw/prefixAdders.sv
`default_nettype none

// parallel-prefix and/or network
// GO[i], PO[i] are the group generate / propagate over bits i..0
module PrefixAndOr #(
	parameter int width = 8,  // word width
	parameter int speed = 1   // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  logic [width-1:0] GI,  // bitwise generate
	input  logic [width-1:0] PI,  // bitwise propagate
	output logic [width-1:0] GO,  // group generate
	output logic [width-1:0] PO   // group propagate
);

	localparam int depth = $clog2(width);  // levels of a log tree

	if (speed == 2) begin : fastPrefix
		// sklansky, depth levels, high fan-out
		logic [width-1:0] gT, pT;

		always_comb begin
			gT = GI;
			pT = PI;
			for (int l = 1; l <= depth; l++) begin
				// k is the first bit of each upper half-block
				for (int k = 1 << (l - 1); k < width; k += 1 << l) begin
					// whole upper half takes the last bit of the lower half
					for (int i = k; i < k + (1 << (l - 1)) && i < width; i++) begin
						gT[i] = gT[i] | (pT[i] & gT[k-1]);
						pT[i] = pT[i] & pT[k-1];
					end
				end
			end
		end

		assign GO = gT;
		assign PO = pT;
	end else if (speed == 1) begin : mediumPrefix
		// brent-kung, about 2*depth levels, low fan-out and few nodes
		logic [width-1:0] gT, pT;

		always_comb begin
			gT = GI;
			pT = PI;
			// up-sweep, spans of 2^l ending at bit 2^l-1, 2*2^l-1, ...
			for (int l = 1; l <= depth; l++) begin
				for (int i = (1 << l) - 1; i < width; i += 1 << l) begin
					gT[i] = gT[i] | (pT[i] & gT[i-(1<<(l-1))]);
					pT[i] = pT[i] & pT[i-(1<<(l-1))];
				end
			end
			// down-sweep fills the bits in between
			for (int l = depth - 1; l >= 1; l--) begin
				for (int i = (1 << l) + (1 << (l - 1)) - 1; i < width; i += 1 << l) begin
					gT[i] = gT[i] | (pT[i] & gT[i-(1<<(l-1))]);
					pT[i] = pT[i] & pT[i-(1<<(l-1))];
				end
			end
		end

		assign GO = gT;
		assign PO = pT;
	end else begin : slowPrefix
		// ripple chain, width-1 levels
		logic [width-1:0] gT, pT;

		always_comb begin
			gT = GI;
			pT = PI;
			for (int i = 1; i < width; i++) begin
				gT[i] = GI[i] | (PI[i] & gT[i-1]);
				pT[i] = PI[i] & pT[i-1];
			end
		end

		assign GO = gT;
		assign PO = pT;
	end

endmodule

// prefix network plus one extra level for the end-around carry
module PrefixAndOrCendaround #(
	parameter int width = 8,  // word width
	parameter int speed = 1   // passed through to the prefix network
) (
	input  logic [width-1:0] GI,
	input  logic [width-1:0] PI,  // bitwise gen/prop
	input  logic             CI,  // carry into bit 0
	output logic [width-1:0] GO,  // carries out of every bit, CI included
	output logic [width-1:0] PO,
	output logic             CO   // carry out of the msb, CI excluded
);

	logic [width-1:0] gT, pT;  // plain prefix result

	PrefixAndOr #(
		.width(width),
		.speed(speed)
	) prefix0 (
		.GI(GI),
		.PI(PI),
		.GO(gT),
		.PO(pT)
	);

	// msb carry does not depend on CI, so feeding CO back to CI is loop free
	assign CO = gT[width-1];

	// fold CI into every position, one and-or deep
	assign GO = gT | (pT & {width{CI}});
	assign PO = pT;

endmodule

// S = A + B mod (2^width - 1)
// all ones is a second zero, e.g. 0 + all ones stays all ones
module AddMod2Nm1 #(
	parameter int width = 8,  // word width
	parameter int speed = 1   // prefix network choice
) (
	input  logic [width-1:0] A,
	input  logic [width-1:0] B,  // operands
	output logic [width-1:0] S   // ones' complement sum
);

	logic [width-1:0] gI, pI;  // bitwise generate / propagate
	logic [width-1:0] hS;      // half sum
	logic [width-1:0] gO;      // carries out of each bit
	logic             cI, cO;  // end-around carry

	assign gI = A & B;
	assign pI = A | B;
	assign hS = A ^ B;

	PrefixAndOrCendaround #(
		.width(width),
		.speed(speed)
	) prefix0 (
		.GI(gI),
		.PI(pI),
		.CI(cI),
		.GO(gO),
		.PO(),   // group propagate not needed for the sum
		.CO(cO)
	);

	// msb carry wraps around into bit 0
	assign cI = cO;

	// carry into bit i is carry out of bit i-1, bit 0 gets the wrapped one
	assign S = hS ^ {gO[width-2:0], cI};

endmodule

`default_nettype wire

// File: hw/csumDecode.sv
`default_nettype none

module csumDecode (
	input  logic              clk,
	input  logic              rstN,
	input  logic              req,      // host request, four-phase
	input  cmdPkg::cmdOp      op,
	input  csumPkg::csumWord  data,
	input  logic              done,     // execute finished
	output logic              issue,    // one-cycle pulse to execute
	output logic              clear,
	output logic              hold,     // read, acc unchanged
	output csumPkg::csumWord  operand,
	output logic              ack
);

	localparam int half = csumPkg::wordWidth / 2;  // byte boundary

	cmdPkg::hsState state;
	logic           start;  // command accepted this cycle

	// ack still high means the last handshake is not finished yet
	assign start = (state == cmdPkg::idle) && req && !ack;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= cmdPkg::idle;
			issue <= 1'b0;
			clear <= 1'b0;
			hold  <= 1'b0;
			ack   <= 1'b0;
		end else begin
			issue <= (state == cmdPkg::issue);  // pulse, state only lasts a cycle
			// high from done until one edge after req is seen low
			ack <= ((state == cmdPkg::waitDone) && done) || (state == cmdPkg::ackHigh);
			if (start) begin
				clear <= (op == cmdPkg::opClear);
				hold  <= (op == cmdPkg::opRead);
			end
			case (state)
				cmdPkg::idle: begin
					if (start) begin
						state <= cmdPkg::issue;
					end
				end
				cmdPkg::issue: begin
					state <= cmdPkg::waitDone;
				end
				cmdPkg::waitDone: begin
					if (done) begin
						state <= cmdPkg::ackHigh;
					end
				end
				cmdPkg::ackHigh: begin
					if (!req) begin
						state <= cmdPkg::idle;  // ack drops one edge later
					end
				end
				default: begin
					state <= cmdPkg::idle;
				end
			endcase
		end
	end

	// operand word, swapped for odd-aligned data
	always_ff @(posedge clk) begin
		if (start) begin
			if (op == cmdPkg::opAddSwap) begin
				operand <= {data[half-1:0], data[csumPkg::wordWidth-1:half]};
			end else begin
				operand <= data;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/csumExecute.sv
`default_nettype none

module csumExecute (
	input  logic              clk,
	input  logic              rstN,
	input  logic              issue,    // command strobe from decode
	input  logic              clear,    // load zero
	input  logic              hold,     // keep acc, read command
	input  csumPkg::csumWord  operand,  // already byte-swapped if needed
	output csumPkg::csumWord  acc,      // running ones' complement sum
	output logic              done      // one cycle after issue
);

	csumPkg::csumWord sumNext;  // acc + operand, end-around carry

	// modulo 2^16-1 adder, structure picked in the package
	AddMod2Nm1 #(
		.width(csumPkg::wordWidth),
		.speed(csumPkg::prefixSpeed)
	) adder0 (
		.A(acc),
		.B(operand),
		.S(sumNext)
	);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			acc  <= '0;
			done <= 1'b0;
		end else begin
			done <= issue;
			if (issue) begin
				if (clear) begin
					acc <= '0;  // positive zero
				end else if (!hold) begin
					acc <= sumNext;
				end
				// hold leaves acc as it is
			end
		end
	end

	// operand and control come from decode registers,
	// stable from the cycle before issue until the next command

endmodule

`default_nettype wire

// File: hw/csumResult.sv
`default_nettype none

module csumResult (
	input  logic              clk,
	input  logic              rstN,
	input  logic              done,      // acc is final this cycle
	input  csumPkg::csumWord  acc,
	output csumPkg::csumWord  sum,       // running sum as presented
	output csumPkg::csumWord  checksum,  // value for the header field
	output logic              ok         // sum is negative zero
);

	logic verify;  // data plus its checksum summed to all ones

	assign verify = (acc == csumPkg::allOnes);

	// outputs only move on done, so they are frozen while ack is high
	always_ff @(posedge clk) begin
		if (!rstN) begin
			sum      <= '0;
			checksum <= '1;   // complement of the zero sum
			ok       <= 1'b0;
		end else if (done) begin
			sum      <= acc;
			checksum <= ~acc;  // bitwise complement
			ok       <= verify;
		end
	end

	// ack rises on the same edge these load,
	// so the host never sees stale values with ack high

endmodule

`default_nettype wire

// File: hw/csumEngine.sv
`default_nettype none

module csumEngine (
	input  logic              clk,
	input  logic              rstN,
	input  logic              req,
	input  cmdPkg::cmdOp      op,
	input  csumPkg::csumWord  data,
	output logic              ack,
	output csumPkg::csumWord  sum,
	output csumPkg::csumWord  checksum,
	output logic              ok
);

	logic             issue;    // decode -> execute strobe
	logic             clear;
	logic             hold;
	csumPkg::csumWord operand;
	csumPkg::csumWord acc;      // execute -> result
	logic             done;     // back to decode and result

	// handshake and command capture
	csumDecode decode0 (
		.clk(clk),
		.rstN(rstN),
		.req(req),
		.op(op),
		.data(data),
		.done(done),
		.issue(issue),
		.clear(clear),
		.hold(hold),
		.operand(operand),
		.ack(ack)
	);

	// accumulator and modulo adder
	csumExecute execute0 (
		.clk(clk),
		.rstN(rstN),
		.issue(issue),
		.clear(clear),
		.hold(hold),
		.operand(operand),
		.acc(acc),
		.done(done)
	);

	// presented outputs
	csumResult result0 (
		.clk(clk),
		.rstN(rstN),
		.done(done),
		.acc(acc),
		.sum(sum),
		.checksum(checksum),
		.ok(ok)
	);

endmodule

`default_nettype wire

// File: tb/csumEngine_assertions.sv
`default_nettype none

module csumEngine_assertions (
	input wire logic              clk,
	input wire logic              rstN,
	input wire logic              req,
	input wire logic              ack,
	input wire csumPkg::csumWord  sum,
	input wire csumPkg::csumWord  checksum,
	input wire logic              ok
);

	int failCount = 0;  // failed assertion evaluations

	// engine may only answer a pending request
	ackRiseNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
		$rose(ack) |-> req)
		else begin
			failCount++;
			$error("ack rose without req");
		end

	// req low must be seen before ack drops
	ackFallAfterReqLow: assert property (@(posedge clk) disable iff (!rstN)
		$fell(ack) |-> !$past(req))
		else begin
			failCount++;
			$error("ack fell while req was still high");
		end

	// results frozen for the whole ack phase
	outputsStable: assert property (@(posedge clk) disable iff (!rstN)
		ack && $past(ack) |-> $stable(sum) && $stable(checksum) && $stable(ok))
		else begin
			failCount++;
			$error("outputs changed while ack high");
		end

	ackLowAfterReset: assert property (@(posedge clk)
		!rstN |=> !ack)
		else begin
			failCount++;
			$error("ack high right after reset");
		end

endmodule

bind csumEngine csumEngine_assertions asrt0 (
	.clk(clk),
	.rstN(rstN),
	.req(req),
	.ack(ack),
	.sum(sum),
	.checksum(checksum),
	.ok(ok)
);

`default_nettype wire

// File: tb/csumEngineTb.sv
`default_nettype none

module csumEngineTb;

	localparam int timeoutCycles = 5000;  // about 300 commands of about 8 cycles plus margin

	logic             clk;
	logic             rstN;
	logic             req;
	cmdPkg::cmdOp     op;
	csumPkg::csumWord data;
	logic             ack;
	csumPkg::csumWord sum;
	csumPkg::csumWord checksum;
	logic             ok;

	csumPkg::csumWord expAcc;          // reference accumulator
	csumPkg::csumWord gotSum, gotChk;  // outputs seen with ack high
	logic             gotOk;
	int               errCount, testErrStart, testsRun, testsFailed, cycleCount;
	string            curTest;

	// ipv4 header with a zero checksum field
	csumPkg::csumWord header [10] = '{16'h4500, 16'h0073, 16'h0000, 16'h4000, 16'h4011,
		16'h0000, 16'hc0a8, 16'h0001, 16'hc0a8, 16'h00c7};

	csumEngine dut0 (
		.clk(clk),
		.rstN(rstN),
		.req(req),
		.op(op),
		.data(data),
		.ack(ack),
		.sum(sum),
		.checksum(checksum),
		.ok(ok)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// run limit
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("timeout: no finish after %0d cycles in %s", timeoutCycles, curTest);
			$display("tests failed");
			$finish;
		end
	end

	// ones' complement add that wraps the carry by subtracting 0xffff
	function automatic csumPkg::csumWord modAdd(input csumPkg::csumWord a,
			input csumPkg::csumWord b);
		logic [16:0] wide;
		wide = {1'b0, a} + {1'b0, b};
		if (wide > 17'h0ffff)
			wide = wide - 17'h0ffff;
		return wide[15:0];
	endfunction

	function automatic csumPkg::csumWord swapBytes(input csumPkg::csumWord w);
		return {w[7:0], w[15:8]};
	endfunction

	task automatic checkValue(input string field, input csumPkg::csumWord expected,
			input csumPkg::csumWord actual);
		if (expected !== actual) begin
			errCount++;
			$display("ERR %s %s: expected %h actual %h", curTest, field, expected, actual);
		end
	endtask

	// one four-phase handshake with optional back-pressure after ack
	task automatic runCommand(input cmdPkg::cmdOp cmd, input csumPkg::csumWord word,
			input int holdCycles);
		@(posedge clk);
		op   <= cmd;
		data <= word;
		req  <= 1'b1;
		do @(negedge clk); while (!ack);
		gotSum = sum;
		gotChk = checksum;
		gotOk  = ok;
		repeat (holdCycles) begin
			@(negedge clk);
			if (!ack) begin
				errCount++;
				$display("%s: ack dropped while req was still held", curTest);
			end
			checkValue("held sum", gotSum, sum);
			checkValue("held checksum", gotChk, checksum);
			checkValue("held ok", {15'b0, gotOk}, {15'b0, ok});
		end
		@(posedge clk);
		req <= 1'b0;
		do @(negedge clk); while (ack);
	endtask

	// update the model, run the command and compare all three outputs
	task automatic applyCommand(input cmdPkg::cmdOp cmd, input csumPkg::csumWord word,
			input int holdCycles);
		case (cmd)
			cmdPkg::opClear:   expAcc = 16'h0000;
			cmdPkg::opAdd:     expAcc = modAdd(expAcc, word);
			cmdPkg::opAddSwap: expAcc = modAdd(expAcc, swapBytes(word));
			default:           expAcc = expAcc;  // read
		endcase
		runCommand(cmd, word, holdCycles);
		checkValue("sum", expAcc, gotSum);
		checkValue("checksum", ~expAcc, gotChk);
		checkValue("ok", {15'b0, expAcc == 16'hffff}, {15'b0, gotOk});
	endtask

	task automatic startTest(input string name);
		curTest      = name;
		testErrStart = errCount;
	endtask

	task automatic finishTest;
		testsRun++;
		if (errCount != testErrStart) begin
			testsFailed++;
			$display("%s: FAIL, %0d errors", curTest, errCount - testErrStart);
		end else begin
			$display("%s: ok", curTest);
		end
	endtask

	task automatic resetState;
		startTest("resetState");
		@(negedge clk);
		if (ack) begin
			errCount++;
			$display("%s: ack high after reset", curTest);
		end
		applyCommand(cmdPkg::opClear, 16'h0000, 0);
		applyCommand(cmdPkg::opRead, 16'h5a5a, 0);  // data must be ignored
		checkValue("read sum", 16'h0000, gotSum);
		checkValue("read checksum", 16'hffff, gotChk);
		finishTest();
	endtask

	task automatic endAroundCarry;
		startTest("endAroundCarry");
		applyCommand(cmdPkg::opClear, 16'h0000, 0);
		applyCommand(cmdPkg::opAdd, 16'hffff, 0);
		applyCommand(cmdPkg::opAdd, 16'h0001, 0);
		checkValue("wrap sum", 16'h0001, gotSum);  // ffff + 1 wraps to 1
		applyCommand(cmdPkg::opRead, 16'h5a5a, 0);  // nonzero sum kept as is
		applyCommand(cmdPkg::opClear, 16'h0000, 0);
		applyCommand(cmdPkg::opAdd, 16'hfffe, 0);
		applyCommand(cmdPkg::opAdd, 16'h0001, 0);
		checkValue("negative zero ok", 16'h0001, {15'b0, gotOk});
		applyCommand(cmdPkg::opAdd, 16'h8000, 0);
		applyCommand(cmdPkg::opAdd, 16'h8000, 0);
		finishTest();
	endtask

	task automatic byteSwap;
		csumPkg::csumWord swapped;
		startTest("byteSwap");
		applyCommand(cmdPkg::opClear, 16'h0000, 0);
		applyCommand(cmdPkg::opAddSwap, 16'h1234, 0);
		swapped = gotSum;
		applyCommand(cmdPkg::opClear, 16'h0000, 0);
		applyCommand(cmdPkg::opAdd, 16'h3412, 0);
		checkValue("swap vs plain", gotSum, swapped);
		finishTest();
	endtask

	task automatic verifyFlag;
		csumPkg::csumWord chk;
		startTest("verifyFlag");
		applyCommand(cmdPkg::opClear, 16'h0000, 0);
		foreach (header[i])
			applyCommand(cmdPkg::opAdd, header[i], 0);
		chk = gotChk;  // field value for this header
		applyCommand(cmdPkg::opClear, 16'h0000, 0);
		foreach (header[i])
			applyCommand(cmdPkg::opAdd, header[i], 0);
		applyCommand(cmdPkg::opAdd, chk, 0);
		checkValue("header verifies", 16'h0001, {15'b0, gotOk});
		// one flipped bit must break it
		applyCommand(cmdPkg::opClear, 16'h0000, 0);
		foreach (header[i])
			applyCommand(cmdPkg::opAdd, (i == 3) ? header[i] ^ 16'h0010 : header[i], 0);
		applyCommand(cmdPkg::opAdd, chk, 0);
		checkValue("corrupt header", 16'h0000, {15'b0, gotOk});
		finishTest();
	endtask

	task automatic randomWords;
		int rnd;  // raw 32-bit draw
		startTest("randomWords");
		applyCommand(cmdPkg::opClear, 16'h0000, 0);
		repeat (200) begin
			rnd = $urandom();
			applyCommand(cmdPkg::opAdd, rnd[15:0], 0);
		end
		finishTest();
	endtask

	task automatic backPressure;
		startTest("backPressure");
		applyCommand(cmdPkg::opClear, 16'h0000, 0);
		applyCommand(cmdPkg::opAdd, 16'h1111, 0);
		applyCommand(cmdPkg::opAdd, 16'h2222, 20);  // req held 20 cycles past ack
		applyCommand(cmdPkg::opAdd, 16'h0303, 0);   // next command still right
		finishTest();
	endtask

	initial begin
		void'($urandom(45));  // single seed for the run
		rstN        = 1'b0;
		req         = 1'b0;
		op          = cmdPkg::opClear;
		data        = 16'h0000;
		expAcc      = 16'h0000;
		errCount    = 0;
		testsRun    = 0;
		testsFailed = 0;
		cycleCount  = 0;
		curTest     = "reset";
		repeat (10) @(posedge clk);
		rstN <= 1'b1;
		resetState();
		endAroundCarry();
		byteSwap();
		verifyFlag();
		randomWords();
		backPressure();
		$display("%0d tests run, %0d failed, %0d errors, %0d assertion failures",
			testsRun, testsFailed, errCount, dut0.asrt0.failCount);
		if (errCount == 0 && dut0.asrt0.failCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: csumEngine.f
hw/csumPkg.sv
hw/cmdPkg.sv
hw/prefixAdders.sv
hw/csumDecode.sv
hw/csumExecute.sv
hw/csumResult.sv
hw/csumEngine.sv
tb/csumEngine_assertions.sv
tb/csumEngineTb.sv
